//--- hdl/fpNextPkg.sv
`default_nettype none

package fpNextPkg;

	// ==================================================================
	// binary32 field layout
	// ==================================================================
	localparam int fpWidth = 32;
	localparam int expWidth = 8;
	localparam int fracWidth = 23;
	localparam logic [expWidth-1:0] expAllOnes = 8'hFF;
	// msb of the fraction marks a quiet nan
	localparam int quietBit = 22;
	localparam logic [fpWidth-1:0] canonicalNan = 32'h7FC0_0000;

	// ==================================================================
	// register map, byte offsets
	// ==================================================================
	localparam logic [3:0] adrA = 4'h0;
	localparam logic [3:0] adrB = 4'h4;
	// ctrl and status share an offset, write vs read
	localparam logic [3:0] adrCtrl = 4'h8;
	localparam logic [3:0] adrStatus = 4'h8;
	localparam logic [3:0] adrResult = 4'hC;

	// result fifo and pipeline sizing
	localparam int fifoDepth = 4;
	localparam int countWidth = 3;
	localparam int pipeDepth = 3;

	typedef enum logic [1:0] {
		opNextAfter = 2'd0,
		opNextUp = 2'd1,
		opNextDown = 2'd2
	} fpOpcode;

	// how stage 3 forms the result word
	typedef enum logic [2:0] {
		dirNanA,
		dirNanB,
		dirEqual,
		dirFromZero,
		dirMagUp,
		dirMagDown
	} stepDir;

	// exponent all ones with any fraction bit set
	function automatic logic isNan(logic [fpWidth-1:0] w);
		return (w[fpWidth-2 -: expWidth] == expAllOnes) && (w[fracWidth-1:0] != '0);
	endfunction

	// zero of either sign
	function automatic logic isZero(logic [fpWidth-1:0] w);
		return w[fpWidth-2:0] == '0;
	endfunction

endpackage

`default_nettype wire

//--- hdl/wbFpRegs.sv
`timescale 1ns/1ps
`default_nettype none

module wbFpRegs import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [3:0] wbAdr,
	input wire logic [fpWidth-1:0] wbDatW,
	input wire logic [3:0] wbSel,
	output logic [fpWidth-1:0] wbDatR,
	output logic wbAck,
	output logic launch,
	output fpOpcode launchOp,
	output logic [fpWidth-1:0] opA,
	output logic [fpWidth-1:0] opB,
	output logic pop,
	input wire logic [countWidth-1:0] fifoCount,
	input wire logic [fpWidth-1:0] popData,
	input wire logic push
);

	logic [3:0] regAdr;
	logic newReq;
	logic isCtrlWr;
	logic isResultRd;
	logic fifoEmpty;
	logic spaceShort;
	logic accept;
	logic [countWidth-1:0] inFlight;
	logic [countWidth:0] occupancy;
	logic [fpWidth-1:0] statusWord;
	fpOpcode wrOp;

	// ==================================================================
	// access decode
	// ==================================================================
	// word aligned offset, byte lanes come from wbSel
	assign regAdr = {wbAdr[3:2], 2'b00};
	// a cycle is new only while ack is low
	assign newReq = wbCyc && wbStb && !wbAck;
	assign isCtrlWr = wbWe && (regAdr == adrCtrl);
	assign isResultRd = !wbWe && (regAdr == adrResult);
	assign fifoEmpty = fifoCount == '0;

	// slots already claimed: queued results plus items in the pipe
	assign occupancy = {1'b0, fifoCount} + {1'b0, inFlight};
	assign spaceShort = occupancy >= (countWidth+1)'(fifoDepth);
	// a ctrl write waits here until a result read frees a slot
	assign accept = newReq && !(isCtrlWr && spaceShort);

	// count in 2:0, busy in 4, last opcode in 9:8
	assign statusWord = {22'd0, launchOp, 3'd0, inFlight != '0, 1'b0, fifoCount};

	// opcode 3 is folded onto nextafter
	always_comb begin
		case (wbDatW[1:0])
			2'd1: wrOp = opNextUp;
			2'd2: wrOp = opNextDown;
			default: wrOp = opNextAfter;
		endcase
	end

	// ==================================================================
	// handshake, launch and operand registers
	// ==================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			launch <= 1'b0;
			launchOp <= opNextAfter;
			pop <= 1'b0;
			inFlight <= '0;
			opA <= '0;
			opB <= '0;
		end else begin
			wbAck <= accept;
			// launch and pop both line up with the ack cycle
			launch <= accept && isCtrlWr;
			pop <= accept && isResultRd && !fifoEmpty;
			if (accept && isCtrlWr)
				launchOp <= wrOp;
			// up on launch, down when stage 3 pushes
			inFlight <= inFlight + countWidth'(launch) - countWidth'(push);
			if (accept && wbWe) begin
				for (int i = 0; i < 4; i++) begin
					if (wbSel[i] && regAdr == adrA)
						opA[8*i +: 8] <= wbDatW[8*i +: 8];
					if (wbSel[i] && regAdr == adrB)
						opB[8*i +: 8] <= wbDatW[8*i +: 8];
				end
			end
		end
	end

	// read data is sampled on the edge that raises ack
	always_ff @(posedge clk) begin
		if (accept && !wbWe) begin
			case (regAdr)
				adrA: wbDatR <= opA;
				adrB: wbDatR <= opB;
				adrStatus: wbDatR <= statusWord;
				// empty read returns a quiet nan and leaves the fifo alone
				adrResult: wbDatR <= fifoEmpty ? canonicalNan : popData;
				default: wbDatR <= '0;
			endcase
		end
	end

	// ack belongs to a strobe the master is still holding
	ackNeedsStb: assert property (@(posedge clk) disable iff (!rstN) wbAck |-> wbStb);

	// back-pressure keeps the pipe no deeper than its stages
	inFlightBound: assert property (@(posedge clk) disable iff (!rstN)
		inFlight <= countWidth'(pipeDepth));

endmodule

`default_nettype wire

//--- hdl/fpClassify.sv
`timescale 1ns/1ps
`default_nettype none

module fpClassify import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic launch,
	input wire fpOpcode launchOp,
	input wire logic [fpWidth-1:0] opA,
	input wire logic [fpWidth-1:0] opB,
	output logic v1,
	output logic [fpWidth-1:0] a1,
	output logic [fpWidth-1:0] t1,
	output logic nanA1,
	output logic nanT1,
	output logic zeroA1
);

	logic [fpWidth-1:0] target;

	// ==================================================================
	// effective target
	// ==================================================================
	// nextup and nextdown are nextafter toward an infinity
	// infinities built from the field layout
	always_comb begin
		case (launchOp)
			opNextUp: target = {1'b0, expAllOnes, {fracWidth{1'b0}}};
			opNextDown: target = {1'b1, expAllOnes, {fracWidth{1'b0}}};
			default: target = opB;
		endcase
	end

	// ==================================================================
	// stage 1 registers
	// ==================================================================
	// valid follows launch with one cycle of delay
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			v1 <= 1'b0;
		else
			v1 <= launch;
	end

	// operands and class flags ride along with v1
	always_ff @(posedge clk) begin
		if (launch) begin
			a1 <= opA;
			t1 <= target;
			// quieting of either nan kind happens in stage 3
			nanA1 <= isNan(opA);
			nanT1 <= isNan(target);
			// sign is ignored so -0 counts as zero
			zeroA1 <= isZero(opA);
		end
	end

endmodule

`default_nettype wire

//--- hdl/fpOrderCompare.sv
`timescale 1ns/1ps
`default_nettype none

module fpOrderCompare import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic v1,
	input wire logic [fpWidth-1:0] a1,
	input wire logic [fpWidth-1:0] t1,
	input wire logic nanA1,
	input wire logic nanT1,
	input wire logic zeroA1,
	output logic v2,
	output logic [fpWidth-1:0] a2,
	output logic [fpWidth-1:0] t2,
	output stepDir dir2
);

	logic [fpWidth-2:0] magA;
	logic [fpWidth-2:0] magT;
	logic sameSign;
	logic equalVal;
	logic tFarther;
	stepDir dirNext;

	// ==================================================================
	// ordering
	// ==================================================================
	// sign magnitude split
	assign magA = a1[fpWidth-2:0];
	assign magT = t1[fpWidth-2:0];
	assign sameSign = a1[fpWidth-1] == t1[fpWidth-1];

	// bit equal, or +0 against -0
	assign equalVal = (a1 == t1) || (zeroA1 && isZero(t1));

	// target lies beyond A on the side away from zero
	// for A > 0 this is t > a, for A < 0 it is t < a
	// opposite signs always step A back toward zero
	assign tFarther = sameSign && (magT > magA);

	// priority order, nans first
	always_comb begin
		if (nanA1)
			dirNext = dirNanA;
		else if (nanT1)
			dirNext = dirNanB;
		else if (equalVal)
			dirNext = dirEqual;
		else if (zeroA1)
			dirNext = dirFromZero;
		else if (tFarther)
			dirNext = dirMagUp;
		else
			dirNext = dirMagDown;
	end

	// ==================================================================
	// stage 2 registers
	// ==================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			v2 <= 1'b0;
		else
			v2 <= v1;
	end

	// payload, captured only for a valid item
	always_ff @(posedge clk) begin
		if (v1) begin
			a2 <= a1;
			t2 <= t1;
			dir2 <= dirNext;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fpStepMagnitude.sv
`timescale 1ns/1ps
`default_nettype none

module fpStepMagnitude import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic v2,
	input wire logic [fpWidth-1:0] a2,
	input wire logic [fpWidth-1:0] t2,
	input wire stepDir dir2,
	output logic push,
	output logic [fpWidth-1:0] pushData
);

	logic [fpWidth-1:0] resultWord;

	// ==================================================================
	// result forming
	// ==================================================================
	// magnitude works as an integer, so max finite + 1 lands on inf
	// and inf - 1 lands on max finite
	always_comb begin
		resultWord = a2;
		case (dir2)
			dirNanA:
				resultWord[quietBit] = 1'b1;
			dirNanB: begin
				resultWord = t2;
				resultWord[quietBit] = 1'b1;
			end
			dirEqual:
				resultWord = t2;
			// smallest subnormal carrying the target sign
			dirFromZero:
				resultWord = {t2[fpWidth-1], {(fpWidth-2){1'b0}}, 1'b1};
			dirMagUp:
				resultWord = {a2[fpWidth-1], a2[fpWidth-2:0] + 1'b1};
			default:
				resultWord = {a2[fpWidth-1], a2[fpWidth-2:0] - 1'b1};
		endcase
	end

	// ==================================================================
	// stage 3 registers
	// ==================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			push <= 1'b0;
		else
			push <= v2;
	end

	always_ff @(posedge clk) begin
		if (v2)
			pushData <= resultWord;
	end

	// stage 2 never asks to step past inf, so only nan inputs yield nan
	nanOnlyFromNan: assert property (@(posedge clk) disable iff (!rstN)
		v2 && isNan(resultWord) |-> (dir2 == dirNanA || dir2 == dirNanB));

endmodule

`default_nettype wire

//--- hdl/resultFifo.sv
`timescale 1ns/1ps
`default_nettype none

module resultFifo import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic push,
	input wire logic [fpWidth-1:0] pushData,
	input wire logic pop,
	output logic [fpWidth-1:0] popData,
	output logic [countWidth-1:0] fifoCount
);

	// pointers are one bit narrower than the count
	logic [countWidth-2:0] wrPtr;
	logic [countWidth-2:0] rdPtr;
	logic [fpWidth-1:0] mem [fifoDepth];
	logic doPop;

	// ==================================================================
	// circular buffer
	// ==================================================================
	// popping an empty fifo does nothing
	assign doPop = pop && (fifoCount != '0);

	// head of queue, valid only while count is nonzero
	assign popData = mem[rdPtr];

	// storage, no reset needed
	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// pointers wrap on their own at depth 4
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// push and pop in one cycle leave the count unchanged
			fifoCount <= fifoCount + countWidth'(push) - countWidth'(doPop);
		end
	end

	// the slave reserves a slot for every launch, so full never sees a push
	noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		push |-> fifoCount != countWidth'(fifoDepth));

endmodule

`default_nettype wire

//--- hdl/nextAfterUnit.sv
`timescale 1ns/1ps
`default_nettype none

module nextAfterUnit import fpNextPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [3:0] wbAdr,
	input wire logic [fpWidth-1:0] wbDatW,
	input wire logic [3:0] wbSel,
	output logic [fpWidth-1:0] wbDatR,
	output logic wbAck
);

	// ==================================================================
	// inter-stage wiring
	// ==================================================================
	// slave to stage 1
	logic launch;
	fpOpcode launchOp;
	logic [fpWidth-1:0] opA;
	logic [fpWidth-1:0] opB;
	// stage 1 to stage 2
	logic v1;
	logic [fpWidth-1:0] a1;
	logic [fpWidth-1:0] t1;
	logic nanA1;
	logic nanT1;
	logic zeroA1;
	// stage 2 to stage 3
	logic v2;
	logic [fpWidth-1:0] a2;
	logic [fpWidth-1:0] t2;
	stepDir dir2;
	// stage 3, fifo and slave read side
	logic push;
	logic [fpWidth-1:0] pushData;
	logic pop;
	logic [fpWidth-1:0] popData;
	logic [countWidth-1:0] fifoCount;

	wbFpRegs regs (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck),
		.launch(launch), .launchOp(launchOp), .opA(opA), .opB(opB),
		.pop(pop), .fifoCount(fifoCount), .popData(popData), .push(push)
	);

	// three stage pipe, one cycle each
	fpClassify classify (
		.clk(clk), .rstN(rstN), .launch(launch), .launchOp(launchOp),
		.opA(opA), .opB(opB), .v1(v1), .a1(a1), .t1(t1),
		.nanA1(nanA1), .nanT1(nanT1), .zeroA1(zeroA1)
	);

	fpOrderCompare compare (
		.clk(clk), .rstN(rstN), .v1(v1), .a1(a1), .t1(t1),
		.nanA1(nanA1), .nanT1(nanT1), .zeroA1(zeroA1),
		.v2(v2), .a2(a2), .t2(t2), .dir2(dir2)
	);

	fpStepMagnitude step (
		.clk(clk), .rstN(rstN), .v2(v2), .a2(a2), .t2(t2), .dir2(dir2),
		.push(push), .pushData(pushData)
	);

	resultFifo fifo (
		.clk(clk), .rstN(rstN), .push(push), .pushData(pushData),
		.pop(pop), .popData(popData), .fifoCount(fifoCount)
	);

endmodule

`default_nettype wire

//--- verif/tbNextAfterUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbNextAfterUnit import fpNextPkg::*; ();

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [3:0] wbAdr;
	logic [31:0] wbDatW;
	logic [3:0] wbSel;
	logic [31:0] wbDatR;
	logic wbAck;
	integer seed;
	logic [31:0] expQ[$];

	nextAfterUnit UUT (
		.clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck)
	);

	// 4 ns period
	always #2 clk = ~clk;

	task automatic failNow(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic valueError(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR %s expected %h got %h", name, exp, got);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// ==================================================================
	// reference model, built from the nextafter rules
	// ==================================================================
	// order is taken on a signed key, -0 and +0 both map to 0
	function automatic logic [31:0] expectNext(input logic [31:0] a, input logic [31:0] b,
		input logic [1:0] op);
		logic [31:0] t;
		logic aNan;
		logic tNan;
		logic up;
		logic signed [32:0] keyA;
		logic signed [32:0] keyT;
		case (op)
			2'd1: t = 32'h7F80_0000;
			2'd2: t = 32'hFF80_0000;
			default: t = b;
		endcase
		aNan = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
		tNan = (t[30:23] == 8'hFF) && (t[22:0] != 23'd0);
		keyA = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
		keyT = t[31] ? -$signed({2'b00, t[30:0]}) : $signed({2'b00, t[30:0]});
		up = (keyA > 0) ? (keyT > keyA) : (keyT < keyA);
		if (aNan)
			return a | 32'h0040_0000;
		else if (tNan)
			return t | 32'h0040_0000;
		else if (keyA == keyT)
			return t;
		else if (keyA == 0)
			return {t[31], 31'd1};
		else if (up)
			return {a[31], a[30:0] + 31'd1};
		else
			return {a[31], a[30:0] - 31'd1};
	endfunction

	// ==================================================================
	// wishbone master
	// ==================================================================
	// ack is looked at on the falling edge, signals drop after the edge that saw it
	task automatic wbAccess(input logic we, input logic [3:0] adr, input logic [31:0] data,
		input logic [3:0] sel, input int limit, output logic acked, output logic [31:0] rdata);
		int waited;
		waited = 0;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = data;
		wbSel = sel;
		@(negedge clk);
		while (!wbAck && waited < limit) begin
			waited++;
			@(negedge clk);
		end
		acked = wbAck;
		rdata = wbDatR;
		@(posedge clk);
		#0.5;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input logic [3:0] adr, input logic [31:0] data, input logic [3:0] sel);
		logic acked;
		logic [31:0] unused;
		wbAccess(1'b1, adr, data, sel, 50, acked, unused);
		if (!acked)
			failNow("write was never acknowledged");
	endtask

	task automatic wbRead(input logic [3:0] adr, output logic [31:0] data);
		logic acked;
		wbAccess(1'b0, adr, 32'd0, 4'hF, 50, acked, data);
		if (!acked)
			failNow("read was never acknowledged");
	endtask

	// poll status until the fifo holds exactly want entries
	task automatic waitCount(input logic [2:0] want);
		logic [31:0] status;
		int polls;
		polls = 0;
		wbRead(adrStatus, status);
		while (status[2:0] != want && polls < 50) begin
			polls++;
			wbRead(adrStatus, status);
		end
		if (status[2:0] != want)
			failNow("result count never reached the expected level");
	endtask

	task automatic readChecked();
		logic [31:0] status;
		logic [31:0] got;
		logic [31:0] exp;
		int polls;
		polls = 0;
		wbRead(adrStatus, status);
		while (status[2:0] == 3'd0 && polls < 50) begin
			polls++;
			wbRead(adrStatus, status);
		end
		if (status[2:0] == 3'd0)
			failNow("no result arrived in the FIFO");
		wbRead(adrResult, got);
		exp = expQ.pop_front();
		assert (got == exp) else valueError("result", exp, got);
	endtask

	task automatic launchOne(input logic [31:0] a, input logic [31:0] b, input logic [1:0] op);
		wbWrite(adrA, a, 4'hF);
		wbWrite(adrB, b, 4'hF);
		wbWrite(adrCtrl, {30'd0, op}, 4'hF);
		expQ.push_back(expectNext(a, b, op));
	endtask

	// hand-derived answer, checked against the model and the unit
	task automatic checkKnown(input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
		assert (expectNext(a, b, 2'd0) == exp) else valueError("model", exp, expectNext(a, b, 2'd0));
		launchOne(a, b, 2'd0);
		readChecked();
	endtask

	// partial byte write over a full one, then read the register back
	task automatic checkReadback(input logic [3:0] adr);
		logic [31:0] oldWord;
		logic [31:0] newWord;
		logic [31:0] exp;
		logic [31:0] got;
		logic [3:0] sel;
		oldWord = $random(seed);
		newWord = $random(seed);
		sel = 4'($random(seed));
		exp = oldWord;
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				exp[8*i +: 8] = newWord[8*i +: 8];
		end
		wbWrite(adr, oldWord, 4'hF);
		wbWrite(adr, newWord, sel);
		wbRead(adr, got);
		assert (got == exp) else valueError(adr == adrA ? "opA" : "opB", exp, got);
	endtask

	// slave rule, ack lasts one cycle and only inside a cycle
	ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
		else failNow("wbAck stayed high for more than one cycle");
	ackInCycle: assert property (@(posedge clk) disable iff (!rstN) wbAck |-> wbCyc)
		else failNow("wbAck rose outside a bus cycle");

	// watchdog against a stuck run
	initial begin
		#200000;
		failNow("simulation ran past its time limit");
	end

	// ==================================================================
	// stimulus
	// ==================================================================
	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] got;
		logic [31:0] status;
		logic acked;
		clk = 1'b0;
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 4'h0;
		wbDatW = 32'd0;
		wbSel = 4'h0;
		seed = 32'hb679_ea7b;
		repeat (10) @(posedge clk);
		#0.5;
		rstN = 1'b1;
		@(posedge clk);
		#0.5;

		// directed steps in each direction
		checkKnown(32'h3F80_0000, 32'h4000_0000, 32'h3F80_0001);
		checkKnown(32'h3F80_0000, 32'h0000_0000, 32'h3F7F_FFFF);
		checkKnown(32'hBF80_0000, 32'hC000_0000, 32'hBF80_0001);
		checkKnown(32'h0000_0000, 32'hBF80_0000, 32'h8000_0001);
		checkKnown(32'h7F7F_FFFF, 32'h7F80_0000, 32'h7F80_0000);
		checkKnown(32'h7F80_0000, 32'h0000_0000, 32'h7F7F_FFFF);
		checkKnown(32'h4049_0FDB, 32'h4049_0FDB, 32'h4049_0FDB);
		checkKnown(32'h0000_0000, 32'h8000_0000, 32'h8000_0000);
		checkKnown(32'h8000_0000, 32'h0000_0000, 32'h0000_0000);
		// nan in A wins, then nan in B, both quieted
		checkKnown(32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0001);
		checkKnown(32'h3F80_0000, 32'hFF81_2345, 32'hFFC1_2345);

		// nextup and nextdown on finite operands
		for (int i = 0; i < 20; i++) begin
			a = $random(seed);
			b = $random(seed);
			if (a[30:23] == 8'hFF)
				a[30] = 1'b0;
			launchOne(a, b, 2'd1);
			readChecked();
			launchOne(a, b, 2'd2);
			readChecked();
		end

		// fill the fifo, a fifth launch must stall until a read
		for (int i = 0; i < 4; i++)
			launchOne($random(seed), $random(seed), 2'($random(seed)));
		waitCount(3'd4);
		a = $random(seed);
		b = $random(seed);
		wbWrite(adrA, a, 4'hF);
		wbWrite(adrB, b, 4'hF);
		wbAccess(1'b1, adrCtrl, 32'd2, 4'hF, 20, acked, got);
		if (acked)
			failNow("control write was acked while the FIFO was full");
		readChecked();
		wbWrite(adrCtrl, 32'd2, 4'hF);
		expQ.push_back(expectNext(a, b, 2'd2));
		while (expQ.size() > 0)
			readChecked();

		// empty fifo gives the canonical nan and an idle status
		wbRead(adrResult, got);
		assert (got == canonicalNan) else valueError("result", canonicalNan, got);
		wbRead(adrStatus, status);
		assert (status == 32'h0000_0200) else valueError("status", 32'h0000_0200, status);

		// random sweep, every eighth pair has equal operands
		for (int j = 0; j < 200; j++) begin
			a = $random(seed);
			b = (j % 8 == 0) ? a : $random(seed);
			launchOne(a, b, 2'($random(seed)));
			readChecked();
		end

		for (int k = 0; k < 8; k++) begin
			checkReadback(adrA);
			checkReadback(adrB);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- nextAfterUnit.f
hdl/fpNextPkg.sv
hdl/wbFpRegs.sv
hdl/fpClassify.sv
hdl/fpOrderCompare.sv
hdl/fpStepMagnitude.sv
hdl/resultFifo.sv
hdl/nextAfterUnit.sv
verif/tbNextAfterUnit.sv

//--- Makefile
# verilator build and run for the nextafter unit

VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing --assert
TOP = tbNextAfterUnit
FILELIST = nextAfterUnit.f
LOG = sim.log
PASS_TEXT = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log is searched for the pass line, a fatal stop never writes it
sim:
	rm -f $(LOG)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
